//--- common/vec_alu_pkg.sv
package vec_alu_pkg;

    //------------------------------------------------------------
    // widths
    //------------------------------------------------------------
    localparam int DATA_W   = 64;   // operand and result word
    localparam int OPCODE_W = 6;

    //------------------------------------------------------------
    // encodings
    //------------------------------------------------------------
    typedef enum logic [OPCODE_W-1:0] {
        op_and   = 6'b000001,
        op_or    = 6'b000010,
        op_xor   = 6'b000011,
        op_not   = 6'b000100,       // data1 only
        op_mov   = 6'b000101,       // data1 only
        op_add   = 6'b000110,
        op_sub   = 6'b000111,
        op_muleu = 6'b001000,       // even lanes, unsigned
        op_mulou = 6'b001001,       // odd lanes, unsigned
        op_sll   = 6'b001010,
        op_srl   = 6'b001011,
        op_sra   = 6'b001100,
        op_rtth  = 6'b001101        // swap halves of each lane
    } opcode_e;

    typedef enum logic [1:0] {
        lw8  = 2'b00,
        lw16 = 2'b01,
        lw32 = 2'b10,
        lw64 = 2'b11
    } lane_width_e;

    // which execute unit owns the result
    typedef enum logic [2:0] {
        cls_none,                   // undefined op, result forced to zero
        cls_logic,
        cls_arith,
        cls_shift,
        cls_mul
    } exec_class_e;

    //------------------------------------------------------------
    // operand word and control
    //------------------------------------------------------------
    typedef union packed {
        logic [7:0][7:0]  b;        // eight bytes
        logic [3:0][15:0] h;        // four halfwords
        logic [1:0][31:0] w;        // two words
        logic [63:0]      d;        // one doubleword
    } vec_word_u;

    typedef struct packed {
        logic        valid;
        exec_class_e cls;
        opcode_e     op;
        lane_width_e width;
        logic        odd_sel;       // odd-lane multiply
    } alu_ctrl_t;

endpackage

//--- src/op_decode.sv
`timescale 1ns/10ps

module op_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic [vec_alu_pkg::OPCODE_W-1:0]    opcode,
    input  logic [1:0]                          ww,
    input  logic [vec_alu_pkg::DATA_W-1:0]      data1,
    input  logic [vec_alu_pkg::DATA_W-1:0]      data2,
    output vec_alu_pkg::alu_ctrl_t              ctrl,
    output vec_alu_pkg::vec_word_u              opa,
    output vec_alu_pkg::vec_word_u              opb
);

    vec_alu_pkg::alu_ctrl_t    ctrl_nxt;
    vec_alu_pkg::lane_width_e  width_in;

    assign width_in = vec_alu_pkg::lane_width_e'(ww);

    //------------------------------------------------------------
    // opcode to execution class
    //------------------------------------------------------------
    always_comb
    begin
        ctrl_nxt.valid   = in_valid;
        ctrl_nxt.op      = vec_alu_pkg::opcode_e'(opcode);
        ctrl_nxt.width   = width_in;
        ctrl_nxt.odd_sel = (opcode == vec_alu_pkg::op_mulou);
        case (opcode)
            vec_alu_pkg::op_and, vec_alu_pkg::op_or, vec_alu_pkg::op_xor,
            vec_alu_pkg::op_not, vec_alu_pkg::op_mov, vec_alu_pkg::op_rtth:
                ctrl_nxt.cls = vec_alu_pkg::cls_logic;
            vec_alu_pkg::op_add, vec_alu_pkg::op_sub:
                ctrl_nxt.cls = vec_alu_pkg::cls_arith;
            vec_alu_pkg::op_sll, vec_alu_pkg::op_srl, vec_alu_pkg::op_sra:
                ctrl_nxt.cls = vec_alu_pkg::cls_shift;
            vec_alu_pkg::op_muleu, vec_alu_pkg::op_mulou:
                // no 128-bit product lane
                ctrl_nxt.cls = (width_in == vec_alu_pkg::lw64) ? vec_alu_pkg::cls_none
                                                               : vec_alu_pkg::cls_mul;
            default:
                ctrl_nxt.cls = vec_alu_pkg::cls_none;    // undefined code
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ctrl <= '0;
        else if (in_valid)
            ctrl <= ctrl_nxt;
        else
            ctrl.valid <= 1'b0;                 // hold fields, drop the strobe
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            opa.d <= data1;
            opb.d <= data2;
        end
    end

endmodule

//--- execute/lane_logic_unit.sv
`timescale 1ns/10ps

module lane_logic_unit (
    input  vec_alu_pkg::alu_ctrl_t              ctrl,
    input  vec_alu_pkg::vec_word_u              opa,
    input  vec_alu_pkg::vec_word_u              opb,
    output logic [vec_alu_pkg::DATA_W-1:0]      logic_res
);

    vec_alu_pkg::vec_word_u res;

    always_comb
    begin
        case (ctrl.op)
            vec_alu_pkg::op_and:  res.d = opa.d & opb.d;
            vec_alu_pkg::op_or:   res.d = opa.d | opb.d;
            vec_alu_pkg::op_xor:  res.d = opa.d ^ opb.d;
            vec_alu_pkg::op_not:  res.d = ~opa.d;
            vec_alu_pkg::op_mov:  res.d = opa.d;
            vec_alu_pkg::op_rtth:
            begin
                case (ctrl.width)
                    vec_alu_pkg::lw8:
                        for (int i = 0; i < 8; i++)
                            res.b[i] = {opa.b[i][3:0], opa.b[i][7:4]};      // nibbles
                    vec_alu_pkg::lw16:
                        for (int i = 0; i < 4; i++)
                            res.h[i] = {opa.h[i][7:0], opa.h[i][15:8]};     // bytes
                    vec_alu_pkg::lw32:
                        for (int i = 0; i < 2; i++)
                            res.w[i] = {opa.w[i][15:0], opa.w[i][31:16]};   // halfwords
                    default:
                        res.d = {opa.d[31:0], opa.d[63:32]};                // words
                endcase
            end
            default:              res.d = '0;
        endcase
    end

    assign logic_res = res.d;

endmodule

//--- execute/lane_arith_unit.sv
`timescale 1ns/10ps

module lane_arith_unit (
    input  vec_alu_pkg::alu_ctrl_t              ctrl,
    input  vec_alu_pkg::vec_word_u              opa,
    input  vec_alu_pkg::vec_word_u              opb,
    output logic [vec_alu_pkg::DATA_W-1:0]      arith_res
);

    logic                   sub;
    vec_alu_pkg::vec_word_u opb_x;      // opb, inverted for subtract
    vec_alu_pkg::vec_word_u res;

    // a - b is a + ~b + 1, with the +1 injected per lane
    assign sub     = (ctrl.op == vec_alu_pkg::op_sub);
    assign opb_x.d = sub ? ~opb.d : opb.d;

    //------------------------------------------------------------
    // one adder per lane, carries stop at the lane edge
    //------------------------------------------------------------
    always_comb
    begin
        case (ctrl.width)
            vec_alu_pkg::lw8:
            begin
                for (int i = 0; i < 8; i++)
                    res.b[i] = opa.b[i] + opb_x.b[i] + {7'd0, sub};
            end
            vec_alu_pkg::lw16:
            begin
                for (int i = 0; i < 4; i++)
                    res.h[i] = opa.h[i] + opb_x.h[i] + {15'd0, sub};
            end
            vec_alu_pkg::lw32:
            begin
                for (int i = 0; i < 2; i++)
                    res.w[i] = opa.w[i] + opb_x.w[i] + {31'd0, sub};
            end
            default:
                res.d = opa.d + opb_x.d + {63'd0, sub};
        endcase
    end

    assign arith_res = res.d;

endmodule

//--- execute/lane_shift_unit.sv
`timescale 1ns/10ps

module lane_shift_unit (
    input  vec_alu_pkg::alu_ctrl_t              ctrl,
    input  vec_alu_pkg::vec_word_u              opa,
    input  vec_alu_pkg::vec_word_u              opb,
    output logic [vec_alu_pkg::DATA_W-1:0]      shift_res
);

    vec_alu_pkg::vec_word_u res;

    // each lane shifts by the low bits of its own opb lane
    always_comb
    begin
        case (ctrl.width)
            vec_alu_pkg::lw8:
            begin
                for (int i = 0; i < 8; i++)
                begin
                    case (ctrl.op)
                        vec_alu_pkg::op_sll: res.b[i] = opa.b[i] << opb.b[i][2:0];
                        vec_alu_pkg::op_srl: res.b[i] = opa.b[i] >> opb.b[i][2:0];
                        vec_alu_pkg::op_sra: res.b[i] = $signed(opa.b[i]) >>> opb.b[i][2:0];
                        default:             res.b[i] = '0;
                    endcase
                end
            end
            vec_alu_pkg::lw16:
            begin
                for (int i = 0; i < 4; i++)
                begin
                    case (ctrl.op)
                        vec_alu_pkg::op_sll: res.h[i] = opa.h[i] << opb.h[i][3:0];
                        vec_alu_pkg::op_srl: res.h[i] = opa.h[i] >> opb.h[i][3:0];
                        vec_alu_pkg::op_sra: res.h[i] = $signed(opa.h[i]) >>> opb.h[i][3:0];
                        default:             res.h[i] = '0;
                    endcase
                end
            end
            vec_alu_pkg::lw32:
            begin
                for (int i = 0; i < 2; i++)
                begin
                    case (ctrl.op)
                        vec_alu_pkg::op_sll: res.w[i] = opa.w[i] << opb.w[i][4:0];
                        vec_alu_pkg::op_srl: res.w[i] = opa.w[i] >> opb.w[i][4:0];
                        vec_alu_pkg::op_sra: res.w[i] = $signed(opa.w[i]) >>> opb.w[i][4:0];
                        default:             res.w[i] = '0;
                    endcase
                end
            end
            default:
            begin
                case (ctrl.op)
                    vec_alu_pkg::op_sll: res.d = opa.d << opb.d[5:0];
                    vec_alu_pkg::op_srl: res.d = opa.d >> opb.d[5:0];
                    vec_alu_pkg::op_sra: res.d = $signed(opa.d) >>> opb.d[5:0];   // sign fill
                    default:             res.d = '0;
                endcase
            end
        endcase
    end

    assign shift_res = res.d;

endmodule

//--- execute/widening_mul_unit.sv
`timescale 1ns/10ps

module widening_mul_unit (
    input  vec_alu_pkg::alu_ctrl_t              ctrl,
    input  vec_alu_pkg::vec_word_u              opa,
    input  vec_alu_pkg::vec_word_u              opb,
    output logic [vec_alu_pkg::DATA_W-1:0]      mul_res
);

    vec_alu_pkg::vec_word_u res;
    logic                   sel;        // picks the odd element of each pair

    assign sel = ctrl.odd_sel;

    //------------------------------------------------------------
    // result lane k is twice the source width, from source pair k
    //------------------------------------------------------------
    always_comb
    begin
        case (ctrl.width)
            vec_alu_pkg::lw8:
            begin
                for (int k = 0; k < 4; k++)
                    res.h[k] = opa.b[2*k + sel] * opb.b[2*k + sel];    // 8x8 to 16
            end
            vec_alu_pkg::lw16:
            begin
                for (int k = 0; k < 2; k++)
                    res.w[k] = opa.h[2*k + sel] * opb.h[2*k + sel];    // 16x16 to 32
            end
            vec_alu_pkg::lw32:
                res.d = opa.w[sel] * opb.w[sel];                     // 32x32 to 64
            default:
                res.d = '0;
        endcase
    end

    assign mul_res = res.d;

endmodule

//--- src/result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  vec_alu_pkg::alu_ctrl_t              ctrl,
    input  logic [vec_alu_pkg::DATA_W-1:0]      logic_res,
    input  logic [vec_alu_pkg::DATA_W-1:0]      arith_res,
    input  logic [vec_alu_pkg::DATA_W-1:0]      shift_res,
    input  logic [vec_alu_pkg::DATA_W-1:0]      mul_res,
    output logic [vec_alu_pkg::DATA_W-1:0]      result,
    output logic                                result_valid
);

    logic [vec_alu_pkg::DATA_W-1:0] res_sel;

    always_comb
    begin
        case (ctrl.cls)
            vec_alu_pkg::cls_logic: res_sel = logic_res;
            vec_alu_pkg::cls_arith: res_sel = arith_res;
            vec_alu_pkg::cls_shift: res_sel = shift_res;
            vec_alu_pkg::cls_mul:   res_sel = mul_res;
            default:                res_sel = '0;      // cls_none
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result       <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= ctrl.valid;         // one pulse per accepted op
            if (ctrl.valid)
                result <= res_sel;              // otherwise hold last value
        end
    end

endmodule

//--- src/vec_alu_top.sv
`timescale 1ns/10ps

module vec_alu_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic [vec_alu_pkg::OPCODE_W-1:0]    opcode,
    input  logic [1:0]                          ww,
    input  logic [vec_alu_pkg::DATA_W-1:0]      data1,
    input  logic [vec_alu_pkg::DATA_W-1:0]      data2,
    output logic [vec_alu_pkg::DATA_W-1:0]      result,
    output logic                                result_valid
);

    vec_alu_pkg::alu_ctrl_t         ctrl;
    vec_alu_pkg::vec_word_u         opa;
    vec_alu_pkg::vec_word_u         opb;
    logic [vec_alu_pkg::DATA_W-1:0] logic_res;
    logic [vec_alu_pkg::DATA_W-1:0] arith_res;
    logic [vec_alu_pkg::DATA_W-1:0] shift_res;
    logic [vec_alu_pkg::DATA_W-1:0] mul_res;

    //------------------------------------------------------------
    // stage 1, decode and operand capture
    //------------------------------------------------------------
    op_decode u_op_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .opcode   (opcode),
        .ww       (ww),
        .data1    (data1),
        .data2    (data2),
        .ctrl     (ctrl),
        .opa      (opa),
        .opb      (opb)
    );

    //------------------------------------------------------------
    // execute units, all in parallel
    //------------------------------------------------------------
    lane_logic_unit u_lane_logic_unit (.ctrl(ctrl), .opa(opa), .opb(opb), .logic_res(logic_res));

    lane_arith_unit u_lane_arith_unit (.ctrl(ctrl), .opa(opa), .opb(opb), .arith_res(arith_res));

    lane_shift_unit u_lane_shift_unit (.ctrl(ctrl), .opa(opa), .opb(opb), .shift_res(shift_res));

    widening_mul_unit u_widening_mul_unit (.ctrl(ctrl), .opa(opa), .opb(opb), .mul_res(mul_res));

    // stage 2, select and register
    result_stage u_result_stage (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .logic_res    (logic_res),
        .arith_res    (arith_res),
        .shift_res    (shift_res),
        .mul_res      (mul_res),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

//--- verification/alu_checker.sv
`timescale 1ns/10ps

module alu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  logic [5:0]  opcode,
    input  logic [1:0]  ww,
    input  logic [63:0] data1,
    input  logic [63:0] data2,
    input  logic [63:0] result,
    input  logic        result_valid,
    input  logic        drain_check,
    output int          mismatch_errs,
    output int          protocol_errs
);

    typedef struct packed {
        logic [63:0] value;
        logic [5:0]  opc;
        logic [1:0]  w;
        logic [31:0] due;                   // cycle in which result_valid must be high
    } exp_entry_t;

    exp_entry_t  exp_q[$];
    exp_entry_t  issued;
    exp_entry_t  head;
    int unsigned edge_count = 0;
    int          value_errs = 0;
    int          order_errs = 0;
    logic        drain_seen = 1'b0;

    assign mismatch_errs = value_errs;
    assign protocol_errs = order_errs;

    //------------------------------------------------------------
    // lane by lane reference model
    //------------------------------------------------------------
    function automatic logic [63:0] model_result(input logic [5:0] opc, input logic [1:0] w,
                                                 input logic [63:0] a, input logic [63:0] b);
        int          n;
        int          sh;
        int          idx;
        logic [63:0] mask;
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] e;
        logic [63:0] r;
        n    = 8 << w;                                  // lane bits
        mask = (n == 64) ? '1 : (64'd1 << n) - 64'd1;
        r    = '0;
        case (opc)
            vec_alu_pkg::op_and: r = a & b;
            vec_alu_pkg::op_or:  r = a | b;
            vec_alu_pkg::op_xor: r = a ^ b;
            vec_alu_pkg::op_not: r = ~a;
            vec_alu_pkg::op_mov: r = a;
            vec_alu_pkg::op_muleu, vec_alu_pkg::op_mulou:
            begin
                for (int k = 0; k < 32 / n; k++)        // no pairs at 64-bit width
                begin
                    idx = 2 * k + ((opc == vec_alu_pkg::op_mulou) ? 1 : 0);
                    x   = (a >> (idx * n)) & mask;
                    y   = (b >> (idx * n)) & mask;
                    r   = r | ((x * y) << (k * 2 * n));
                end
            end
            vec_alu_pkg::op_add, vec_alu_pkg::op_sub, vec_alu_pkg::op_sll,
            vec_alu_pkg::op_srl, vec_alu_pkg::op_sra, vec_alu_pkg::op_rtth:
            begin
                for (int i = 0; i < 64 / n; i++)
                begin
                    x  = (a >> (i * n)) & mask;
                    y  = (b >> (i * n)) & mask;
                    sh = y % n;                         // low log2(n) bits of the lane
                    case (opc)
                        vec_alu_pkg::op_add: e = x + y;
                        vec_alu_pkg::op_sub: e = x - y;
                        vec_alu_pkg::op_sll: e = x << sh;
                        vec_alu_pkg::op_srl: e = x >> sh;
                        vec_alu_pkg::op_sra: e = (x >> sh) | (x[n-1] ? ~(mask >> sh) : '0);
                        default:             e = (x << (n / 2)) | (x >> (n / 2));
                    endcase
                    r = r | ((e & mask) << (i * n));
                end
            end
            default: r = '0;                            // undefined code
        endcase
        return r;
    endfunction

    // inputs change 5 ns after the edge, so they are stable here
    always @(posedge clk)
    begin
        edge_count = edge_count + 1;
        if (!rst && in_valid === 1'b1)
        begin
            issued.value = model_result(opcode, ww, data1, data2);
            issued.opc   = opcode;
            issued.w     = ww;
            issued.due   = edge_count + 1;              // sampled at the edge after that
            exp_q.push_back(issued);
        end
    end

    //------------------------------------------------------------
    // compare at the falling edge
    //------------------------------------------------------------
    always @(negedge clk)
    begin
        if (edge_count > 0 && result_valid !== 1'b0)
        begin
            if (exp_q.size() == 0)
            begin
                $display("result_valid pulsed at %0t with no operation outstanding", $time);
                order_errs = order_errs + 1;
            end
            else
            begin
                head = exp_q.pop_front();
                if (head.due != edge_count)
                begin
                    $display("result arrived on cycle %0d but was due on cycle %0d",
                             edge_count, head.due);
                    order_errs = order_errs + 1;
                end
                if (result !== head.value)
                begin
                    $display("Error at %0t: opcode %02h width %0d expected %016h actual %016h",
                             $time, head.opc, 8 << head.w, head.value, result);
                    value_errs = value_errs + 1;
                end
            end
        end
        else if (exp_q.size() != 0 && exp_q[0].due <= edge_count)
        begin
            head = exp_q.pop_front();
            $display("no result_valid for opcode %02h on cycle %0d", head.opc, head.due);
            order_errs = order_errs + 1;
        end
        if (drain_check && !drain_seen)
        begin
            drain_seen = 1'b1;
            if (exp_q.size() != 0)
            begin
                $display("%0d results were expected but never arrived", exp_q.size());
                order_errs = order_errs + 1;
            end
        end
    end

endmodule

//--- verification/tb_vec_alu.sv
`timescale 1ns/10ps

module tb_vec_alu;

    localparam int NUM_OPS        = 600;
    localparam int TIMEOUT_CYCLES = 2000;   // ops, idle cycles, reset and drain

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [5:0]  opcode;
    logic [1:0]  ww;
    logic [63:0] data1;
    logic [63:0] data2;
    logic [63:0] result;
    logic        result_valid;
    logic        drain_check;
    int          mismatch_errs;
    int          protocol_errs;
    integer      seed = 15;
    int          ops_issued = 0;
    int          cycles = 0;

    vec_alu_top u_vec_alu_top (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .opcode       (opcode),
        .ww           (ww),
        .data1        (data1),
        .data2        (data2),
        .result       (result),
        .result_valid (result_valid)
    );

    alu_checker u_alu_checker (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .opcode        (opcode),
        .ww            (ww),
        .data1         (data1),
        .data2         (data2),
        .result        (result),
        .result_valid  (result_valid),
        .drain_check   (drain_check),
        .mismatch_errs (mismatch_errs),
        .protocol_errs (protocol_errs)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    //------------------------------------------------------------
    // stimulus helpers
    //------------------------------------------------------------
    task automatic issue_op(input logic [5:0] opc, input logic [1:0] w,
                            input logic [63:0] d1, input logic [63:0] d2);
        @(posedge clk);
        #5;
        in_valid   = 1'b1;
        opcode     = opc;
        ww         = w;
        data1      = d1;
        data2      = d2;
        ops_issued = ops_issued + 1;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #5;
        in_valid = 1'b0;
    endtask

    // same lane value in every lane of width w
    function automatic logic [63:0] fill_lanes(input logic [1:0] w, input logic [63:0] lane_val);
        logic [63:0] r;
        int          n;
        n = 8 << w;
        r = '0;
        for (int i = 0; i < 64 / n; i++)
            r = r | (lane_val << (i * n));
        return r;
    endfunction

    // three quarters from the kept codes, which are contiguous
    function automatic logic [5:0] pick_opcode();
        logic [5:0] code;
        code = 6'($random(seed));
        if (($random(seed) & 3) != 0)
            code = 6'(vec_alu_pkg::op_and + $unsigned($random(seed)) % 13);
        return code;
    endfunction

    initial
    begin
        logic [63:0] neg;
        rst         = 1'b1;
        in_valid    = 1'b0;
        opcode      = '0;
        ww          = '0;
        data1       = '0;
        data2       = '0;
        drain_check = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        repeat (3) idle_cycle();                        // result_valid stays low here

        for (int w = 0; w < 4; w++)                     // carries at every width
        begin
            issue_op(vec_alu_pkg::op_add, 2'(w), '1, '1);
            issue_op(vec_alu_pkg::op_add, 2'(w), '1, fill_lanes(2'(w), 64'd1));
            issue_op(vec_alu_pkg::op_sub, 2'(w), '0, fill_lanes(2'(w), 64'd1));
            issue_op(vec_alu_pkg::op_rtth, 2'(w), {$random(seed), $random(seed)}, '0);
        end
        for (int w = 0; w < 4; w++)                     // negative lanes, largest amounts
        begin
            neg = {$random(seed), $random(seed)} | fill_lanes(2'(w), 64'd1 << ((8 << w) - 1));
            issue_op(vec_alu_pkg::op_sra, 2'(w), neg, '1);
            issue_op(vec_alu_pkg::op_srl, 2'(w), neg, '1);
            issue_op(vec_alu_pkg::op_sll, 2'(w), neg, '1);
        end
        for (int w = 0; w < 3; w++)
        begin
            issue_op(vec_alu_pkg::op_muleu, 2'(w), '1, '1);
            issue_op(vec_alu_pkg::op_mulou, 2'(w), '1, '1);
        end
        issue_op(6'h00, vec_alu_pkg::lw8, '1, '1);      // undefined codes
        issue_op(6'h3f, vec_alu_pkg::lw32, '1, '1);
        issue_op(vec_alu_pkg::op_muleu, vec_alu_pkg::lw64, '1, '1);
        issue_op(vec_alu_pkg::op_mulou, vec_alu_pkg::lw64, '1, '1);

        //------------------------------------------------------------
        // random traffic, valid on about three cycles in four
        //------------------------------------------------------------
        while (ops_issued < NUM_OPS)
        begin
            if (($random(seed) & 3) != 0)
                issue_op(pick_opcode(), 2'($random(seed)),
                         {$random(seed), $random(seed)}, {$random(seed), $random(seed)});
            else
                idle_cycle();
        end

        repeat (3) idle_cycle();                        // two-cycle latency drains here
        drain_check = 1'b1;
        @(posedge clk);
        $display("errors: %0d value mismatches, %0d protocol errors",
                 mismatch_errs, protocol_errs);
        if (mismatch_errs + protocol_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- src.f
common/vec_alu_pkg.sv
src/op_decode.sv
execute/lane_logic_unit.sv
execute/lane_arith_unit.sv
execute/lane_shift_unit.sv
execute/widening_mul_unit.sv
src/result_stage.sv
src/vec_alu_top.sv
verification/alu_checker.sv
verification/tb_vec_alu.sv
